//--- deparser.f
+incdir+include
rtl/deparser_pkg.sv
rtl/parse_action_table.sv
rtl/container_extract.sv
rtl/header_buffer.sv
rtl/deparse_ctrl.sv
rtl/deparser_top.sv
tests/tb_deparser.sv

//--- Bender.yml
package:
  name: deparser

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/deparser_pkg.sv
      - rtl/parse_action_table.sv
      - rtl/container_extract.sv
      - rtl/header_buffer.sv
      - rtl/deparse_ctrl.sv
      - rtl/deparser_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tests/tb_deparser.sv

//--- tests/tb_deparser.sv
`timescale 1ns/10ps
`default_nettype none

`include "deparser_params.svh"

module tb_deparser;

	localparam int BEAT_W = `DEP_DATA_W + `DEP_KEEP_W + `DEP_USER_W + 1;
	localparam int KEEP_LSB = `DEP_DATA_W;
	localparam int USER_LSB = `DEP_DATA_W + `DEP_KEEP_W;
	localparam int RAND_PKTS = 12;
	localparam int RAND_MAX_LEN = 6;
	localparam int TOTAL_BEATS = 1 + 2 + 9 + 5 + RAND_PKTS * RAND_MAX_LEN;
	localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40;
	localparam logic [31:0] RAND_SEED = 32'h0502_4a65;

	typedef logic [BEAT_W-1:0] beat_t;

	logic                          clk;
	logic                          aresetn;
	logic [`DEP_DATA_W-1:0]        pkt_fifo_tdata;
	logic [`DEP_KEEP_W-1:0]        pkt_fifo_tkeep;
	logic [`DEP_USER_W-1:0]        pkt_fifo_tuser;
	logic                          pkt_fifo_tlast;
	logic                          pkt_fifo_empty;
	logic                          pkt_fifo_rd_en;
	logic [`DEP_PHV_W-1:0]         phv_fifo_out;
	logic                          phv_fifo_empty;
	logic                          phv_fifo_rd_en;
	logic                          tbl_wr_en;
	logic [`DEP_TBL_ADDR_W-1:0]    tbl_wr_addr;
	logic [`DEP_ENTRY_W-1:0]       tbl_wr_data;
	logic [`DEP_DATA_W-1:0]        depar_out_tdata;
	logic [`DEP_KEEP_W-1:0]        depar_out_tkeep;
	logic [`DEP_USER_W-1:0]        depar_out_tuser;
	logic                          depar_out_tvalid;
	logic                          depar_out_tlast;
	logic                          depar_out_tready;

	// source queues hold data not yet arrived and fifo queues what the DUT sees
	beat_t                   pkt_src_q [$];
	beat_t                   pkt_fifo_q [$];
	logic [`DEP_PHV_W-1:0]   phv_src_q [$];
	logic [`DEP_PHV_W-1:0]   phv_fifo_q [$];
	beat_t                   exp_q [$];
	logic [`DEP_ENTRY_W-1:0] tbl_model [`DEP_TBL_DEPTH];
	logic                    gaps_on;
	logic                    rand_ready;
	int                      errors;
	int                      checks;
	int                      test_num;
	int                      errors_at_start;
	int                      checks_at_start;

	deparser_top i_dut (
		.clk              (clk),
		.aresetn          (aresetn),
		.pkt_fifo_tdata   (pkt_fifo_tdata),
		.pkt_fifo_tkeep   (pkt_fifo_tkeep),
		.pkt_fifo_tuser   (pkt_fifo_tuser),
		.pkt_fifo_tlast   (pkt_fifo_tlast),
		.pkt_fifo_empty   (pkt_fifo_empty),
		.pkt_fifo_rd_en   (pkt_fifo_rd_en),
		.phv_fifo_out     (phv_fifo_out),
		.phv_fifo_empty   (phv_fifo_empty),
		.phv_fifo_rd_en   (phv_fifo_rd_en),
		.tbl_wr_en        (tbl_wr_en),
		.tbl_wr_addr      (tbl_wr_addr),
		.tbl_wr_data      (tbl_wr_data),
		.depar_out_tdata  (depar_out_tdata),
		.depar_out_tkeep  (depar_out_tkeep),
		.depar_out_tuser  (depar_out_tuser),
		.depar_out_tvalid (depar_out_tvalid),
		.depar_out_tlast  (depar_out_tlast),
		.depar_out_tready (depar_out_tready)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic logic [15:0] action_word(input logic valid, input logic [1:0] kind,
			input logic [2:0] idx, input logic [6:0] ofs);
		return {3'b000, ofs, kind, idx, valid};
	endfunction

	// expected header built byte by byte from the action list
	function automatic logic [`DEP_HDR_W-1:0] rewrite_header(input logic [`DEP_PHV_W-1:0] phv,
			input logic [`DEP_ENTRY_W-1:0] entry, input logic [`DEP_HDR_W-1:0] hdr);
		logic [15:0]           act;
		logic [`DEP_HDR_W-1:0] res;
		int                    nbytes;
		int                    ofs;
		int                    src;
		res = hdr;
		for (int k = 0; k < `DEP_NUM_ACT; k++) begin
			act = entry[k*16 +: 16];
			nbytes = 2 * act[5:4];
			ofs = act[12:6];
			case (act[5:4])
				2'd1: src = `DEP_CONT2_OFS;
				2'd2: src = `DEP_CONT4_OFS;
				default: src = `DEP_CONT6_OFS;
			endcase
			src = `DEP_CONT_LSB + src + act[3:1] * nbytes * 8;
			if (act[0] && nbytes != 0 && ofs + nbytes <= `DEP_HDR_W / 8) begin
				for (int b = 0; b < nbytes; b++) begin
					res[(ofs + b)*8 +: 8] = phv[src + b*8 +: 8];
				end
			end
		end
		return res;
	endfunction

	task automatic write_entry(input logic [3:0] addr, input logic [`DEP_ENTRY_W-1:0] data);
		@(posedge clk);
		#2;
		tbl_wr_en = 1'b1;
		tbl_wr_addr = addr;
		tbl_wr_data = data;
		@(posedge clk);
		#2;
		tbl_wr_en = 1'b0;
		tbl_model[addr] = data;
	endtask

	task automatic send_packet(input logic [11:0] vlan, input int nbeats);
		logic [1151:0]          fill;
		logic [`DEP_PHV_W-1:0]  phv;
		logic [`DEP_HDR_W-1:0]  hdr;
		logic [`DEP_HDR_W-1:0]  new_hdr;
		logic [`DEP_DATA_W-1:0] data;
		logic [`DEP_KEEP_W-1:0] keep;
		logic [`DEP_USER_W-1:0] user;
		logic                   last;
		beat_t                  beats [$];
		beat_t                  b;
		for (int i = 0; i < 36; i++) begin
			fill[i*32 +: 32] = $urandom;
		end
		phv = fill[`DEP_PHV_W-1:0];
		phv[`DEP_VLAN_LSB +: `DEP_VLAN_W] = vlan;
		hdr = '0;
		for (int i = 0; i < nbeats; i++) begin
			for (int w = 0; w < 8; w++) begin
				data[w*32 +: 32] = $urandom;
			end
			for (int w = 0; w < 4; w++) begin
				user[w*32 +: 32] = $urandom;
			end
			last = (i == nbeats - 1);
			keep = last ? ({32{1'b1}} >> $urandom_range(0, 31)) : {32{1'b1}};
			beats.push_back({last, user, keep, data});
			if (i < 2) begin
				hdr[i*`DEP_DATA_W +: `DEP_DATA_W] = data;
			end
		end
		new_hdr = rewrite_header(phv, tbl_model[vlan[7:4]], hdr);
		for (int i = 0; i < nbeats; i++) begin
			b = beats[i];
			if (i < 2) begin
				b[`DEP_DATA_W-1:0] = new_hdr[i*`DEP_DATA_W +: `DEP_DATA_W];
			end
			exp_q.push_back(b);
			pkt_src_q.push_back(beats[i]);
		end
		phv_src_q.push_back(phv);
	endtask

	task automatic start_test();
		test_num++;
		errors_at_start = errors;
		checks_at_start = checks;
		@(negedge clk);
	endtask

	task automatic end_test(input string name);
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		$display("test %0d %s: %0d beats checked, %0d errors", test_num, name,
			checks - checks_at_start, errors - errors_at_start);
	endtask

	// show-ahead FIFO models and the output ready
	initial begin : fifo_driver
		logic pkt_pop;
		logic phv_pop;
		pkt_fifo_tdata = '0;
		pkt_fifo_tkeep = '0;
		pkt_fifo_tuser = '0;
		pkt_fifo_tlast = 1'b0;
		pkt_fifo_empty = 1'b1;
		phv_fifo_out = '0;
		phv_fifo_empty = 1'b1;
		depar_out_tready = 1'b0;
		forever begin
			@(posedge clk);
			pkt_pop = pkt_fifo_rd_en;
			phv_pop = phv_fifo_rd_en;
			#2;
			if (pkt_pop && pkt_fifo_q.size() == 0) begin
				$display("packet FIFO read while empty at %0t", $time);
				errors++;
			end else if (pkt_pop) begin
				void'(pkt_fifo_q.pop_front());
			end
			if (phv_pop && phv_fifo_q.size() == 0) begin
				$display("PHV FIFO read while empty at %0t", $time);
				errors++;
			end else if (phv_pop) begin
				void'(phv_fifo_q.pop_front());
			end
			if (gaps_on) begin
				if (pkt_src_q.size() != 0 && $urandom_range(0, 2) != 0) begin
					pkt_fifo_q.push_back(pkt_src_q.pop_front());
				end
				if (phv_src_q.size() != 0 && $urandom_range(0, 2) != 0) begin
					phv_fifo_q.push_back(phv_src_q.pop_front());
				end
			end else begin
				while (pkt_src_q.size() != 0) begin
					pkt_fifo_q.push_back(pkt_src_q.pop_front());
				end
				while (phv_src_q.size() != 0) begin
					phv_fifo_q.push_back(phv_src_q.pop_front());
				end
			end
			pkt_fifo_empty = (pkt_fifo_q.size() == 0);
			if (!pkt_fifo_empty) begin
				{pkt_fifo_tlast, pkt_fifo_tuser, pkt_fifo_tkeep, pkt_fifo_tdata} = pkt_fifo_q[0];
			end
			phv_fifo_empty = (phv_fifo_q.size() == 0);
			if (!phv_fifo_empty) begin
				phv_fifo_out = phv_fifo_q[0];
			end
			depar_out_tready = rand_ready ? ($urandom_range(0, 3) != 0) : 1'b1;
		end
	end

	always @(posedge clk) begin : compare_beats
		beat_t got;
		beat_t want;
		if (aresetn && depar_out_tvalid && depar_out_tready) begin
			got = {depar_out_tlast, depar_out_tuser, depar_out_tkeep, depar_out_tdata};
			if (exp_q.size() == 0) begin
				$display("extra beat accepted at %0t while no beat was expected", $time);
				errors++;
			end else begin
				want = exp_q.pop_front();
				checks++;
				if (got[`DEP_DATA_W-1:0] !== want[`DEP_DATA_W-1:0]) begin
					$display("FAILED at %0t: tdata %h, expected %h", $time,
						got[`DEP_DATA_W-1:0], want[`DEP_DATA_W-1:0]);
					errors++;
				end
				if (got[KEEP_LSB +: `DEP_KEEP_W] !== want[KEEP_LSB +: `DEP_KEEP_W]) begin
					$display("FAILED at %0t: tkeep %h, expected %h", $time,
						got[KEEP_LSB +: `DEP_KEEP_W], want[KEEP_LSB +: `DEP_KEEP_W]);
					errors++;
				end
				if (got[USER_LSB +: `DEP_USER_W] !== want[USER_LSB +: `DEP_USER_W]) begin
					$display("FAILED at %0t: tuser %h, expected %h", $time,
						got[USER_LSB +: `DEP_USER_W], want[USER_LSB +: `DEP_USER_W]);
					errors++;
				end
				if (got[BEAT_W-1] !== want[BEAT_W-1]) begin
					$display("FAILED at %0t: tlast %b, expected %b", $time,
						got[BEAT_W-1], want[BEAT_W-1]);
					errors++;
				end
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles, %0d expected beats never arrived",
			WATCHDOG_CYCLES, exp_q.size());
		$display("Checks failed");
		$finish;
	end

	initial begin : run_tests
		logic [`DEP_ENTRY_W-1:0] entry;
		logic [11:0]             vlan;
		void'($urandom(RAND_SEED));
		errors = 0;
		checks = 0;
		test_num = 0;
		gaps_on = 1'b0;
		rand_ready = 1'b0;
		aresetn = 1'b0;
		tbl_wr_en = 1'b0;
		tbl_wr_addr = '0;
		tbl_wr_data = '0;
		repeat (2) @(posedge clk);
		#2;
		aresetn = 1'b1;

		entry = '0;
		entry[0 +: 16] = action_word(1'b1, 2'd1, 3'd3, 7'd5);
		write_entry(4'd1, entry);
		start_test();
		send_packet(12'h01a, 1);
		end_test("single beat, one 2-byte container");

		// action 3 overlaps action 0 and the later one should win
		entry = '0;
		entry[0 +: 16] = action_word(1'b1, 2'd1, 3'd0, 7'd10);
		entry[16 +: 16] = action_word(1'b1, 2'd2, 3'd5, 7'd30);
		entry[32 +: 16] = action_word(1'b1, 2'd3, 3'd7, 7'd50);
		entry[48 +: 16] = action_word(1'b1, 2'd3, 3'd2, 7'd8);
		entry[64 +: 16] = action_word(1'b1, 2'd2, 3'd1, 7'd58);
		entry[80 +: 16] = action_word(1'b1, 2'd1, 3'd4, 7'd33);
		write_entry(4'd2, entry);
		start_test();
		send_packet(12'h025, 2);
		end_test("two beats, mixed sizes with overlap");

		entry = '0;
		entry[0 +: 16] = action_word(1'b1, 2'd3, 3'd0, 7'd0);
		entry[144 +: 16] = action_word(1'b1, 2'd2, 3'd3, 7'd44);
		write_entry(4'd3, entry);
		start_test();
		send_packet(12'h030, 9);
		end_test("long packet, body unchanged");

		// invalid, type 0 and out-of-range writes mixed with real ones
		entry = '0;
		entry[0 +: 16] = action_word(1'b0, 2'd2, 3'd1, 7'd0);
		entry[16 +: 16] = action_word(1'b1, 2'd0, 3'd2, 7'd4);
		entry[32 +: 16] = action_word(1'b1, 2'd3, 3'd5, 7'd60);
		entry[48 +: 16] = action_word(1'b1, 2'd1, 3'd0, 7'd63);
		entry[64 +: 16] = action_word(1'b1, 2'd1, 3'd6, 7'd62);
		entry[80 +: 16] = action_word(1'b1, 2'd2, 3'd4, 7'd16);
		write_entry(4'd4, entry);
		entry = '0;
		entry[0 +: 16] = action_word(1'b1, 2'd3, 3'd1, 7'd0);
		entry[16 +: 16] = action_word(1'b1, 2'd2, 3'd7, 7'd40);
		write_entry(4'd5, entry);
		start_test();
		send_packet(12'h047, 2);
		send_packet(12'h058, 2);
		send_packet(12'ha4f, 1);
		end_test("per-vlan entries and skipped actions");

		for (int a = 0; a < `DEP_TBL_DEPTH; a++) begin
			for (int w = 0; w < 5; w++) begin
				entry[w*32 +: 32] = $urandom;
			end
			write_entry(a[3:0], entry);
		end
		gaps_on = 1'b1;
		rand_ready = 1'b1;
		start_test();
		for (int p = 0; p < RAND_PKTS; p++) begin
			vlan = $urandom;
			send_packet(vlan, $urandom_range(1, RAND_MAX_LEN));
		end
		end_test("random back-pressure and FIFO gaps");
		gaps_on = 1'b0;
		rand_ready = 1'b0;

		repeat (20) @(posedge clk);
		if (pkt_src_q.size() + pkt_fifo_q.size() != 0) begin
			$display("packet FIFO still holds %0d beats at end of run",
				pkt_src_q.size() + pkt_fifo_q.size());
			errors++;
		end
		if (phv_src_q.size() + phv_fifo_q.size() != 0) begin
			$display("PHV FIFO still holds %0d entries at end of run",
				phv_src_q.size() + phv_fifo_q.size());
			errors++;
		end
		$display("summary: %0d tests, %0d beats checked, %0d errors", test_num, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/deparser_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "deparser_params.svh"

module deparser_top (
	input  logic                         clk,
	input  logic                         aresetn,
	input  logic [`DEP_DATA_W-1:0]       pkt_fifo_tdata,
	input  logic [`DEP_KEEP_W-1:0]       pkt_fifo_tkeep,
	input  logic [`DEP_USER_W-1:0]       pkt_fifo_tuser,
	input  logic                         pkt_fifo_tlast,
	input  logic                         pkt_fifo_empty,
	output logic                         pkt_fifo_rd_en,
	input  logic [`DEP_PHV_W-1:0]        phv_fifo_out,
	input  logic                         phv_fifo_empty,
	output logic                         phv_fifo_rd_en,
	input  logic                         tbl_wr_en,
	input  logic [`DEP_TBL_ADDR_W-1:0]   tbl_wr_addr,
	input  logic [`DEP_ENTRY_W-1:0]      tbl_wr_data,
	output logic [`DEP_DATA_W-1:0]       depar_out_tdata,
	output logic [`DEP_KEEP_W-1:0]       depar_out_tkeep,
	output logic [`DEP_USER_W-1:0]       depar_out_tuser,
	output logic                         depar_out_tvalid,
	output logic                         depar_out_tlast,
	input  logic                         depar_out_tready
);

	deparser_pkg::parse_action_u  actions [`DEP_NUM_ACT];
	logic [`DEP_VLAN_W-1:0]       vlan_id;
	logic [`DEP_CONT_W-1:0]       containers;
	logic [`DEP_OFS_W-1:0]        offsets [`DEP_NUM_ACT];
	logic [`DEP_VAL_W-1:0]        values [`DEP_NUM_ACT];
	logic [1:0]                   sizes [`DEP_NUM_ACT];
	logic                         capture_lo;
	logic                         capture_hi;
	logic                         extract;
	logic                         apply;
	logic                         sel_hi;
	logic [`DEP_DATA_W-1:0]       beat_tdata;
	logic [`DEP_KEEP_W-1:0]       beat_tkeep;
	logic [`DEP_USER_W-1:0]       beat_tuser;
	logic                         beat_tlast;

	// phv head stays put until the rewrite pops it
	assign vlan_id    = phv_fifo_out[`DEP_VLAN_LSB +: `DEP_VLAN_W];
	assign containers = phv_fifo_out[`DEP_CONT_LSB +: `DEP_CONT_W];

	parse_action_table i_table (
		.clk         (clk),
		.aresetn     (aresetn),
		.tbl_wr_en   (tbl_wr_en),
		.tbl_wr_addr (tbl_wr_addr),
		.tbl_wr_data (tbl_wr_data),
		.vlan_id     (vlan_id),
		.actions     (actions)
	);

	for (genvar k = 0; k < `DEP_NUM_ACT; k++) begin : g_extract
		assign offsets[k] = actions[k].fields.byte_offset;

		container_extract i_extract (
			.clk        (clk),
			.aresetn    (aresetn),
			.extract    (extract),
			.containers (containers),
			.action     (actions[k]),
			.value      (values[k]),
			.size       (sizes[k])
		);
	end

	header_buffer i_buffer (
		.clk        (clk),
		.aresetn    (aresetn),
		.capture_lo (capture_lo),
		.capture_hi (capture_hi),
		.apply      (apply),
		.pkt_tdata  (pkt_fifo_tdata),
		.pkt_tkeep  (pkt_fifo_tkeep),
		.pkt_tuser  (pkt_fifo_tuser),
		.pkt_tlast  (pkt_fifo_tlast),
		.offsets    (offsets),
		.values     (values),
		.sizes      (sizes),
		.sel_hi     (sel_hi),
		.beat_tdata (beat_tdata),
		.beat_tkeep (beat_tkeep),
		.beat_tuser (beat_tuser),
		.beat_tlast (beat_tlast)
	);

	deparse_ctrl i_ctrl (
		.clk              (clk),
		.aresetn          (aresetn),
		.pkt_fifo_empty   (pkt_fifo_empty),
		.pkt_fifo_tdata   (pkt_fifo_tdata),
		.pkt_fifo_tkeep   (pkt_fifo_tkeep),
		.pkt_fifo_tuser   (pkt_fifo_tuser),
		.pkt_fifo_tlast   (pkt_fifo_tlast),
		.phv_fifo_empty   (phv_fifo_empty),
		.depar_out_tready (depar_out_tready),
		.beat_tdata       (beat_tdata),
		.beat_tkeep       (beat_tkeep),
		.beat_tuser       (beat_tuser),
		.beat_tlast       (beat_tlast),
		.pkt_fifo_rd_en   (pkt_fifo_rd_en),
		.phv_fifo_rd_en   (phv_fifo_rd_en),
		.capture_lo       (capture_lo),
		.capture_hi       (capture_hi),
		.extract          (extract),
		.apply            (apply),
		.sel_hi           (sel_hi),
		.depar_out_tdata  (depar_out_tdata),
		.depar_out_tkeep  (depar_out_tkeep),
		.depar_out_tuser  (depar_out_tuser),
		.depar_out_tvalid (depar_out_tvalid),
		.depar_out_tlast  (depar_out_tlast)
	);

endmodule

`default_nettype wire

//--- rtl/deparse_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "deparser_params.svh"

module deparse_ctrl (
	input  logic                      clk,
	input  logic                      aresetn,
	input  logic                      pkt_fifo_empty,
	input  logic [`DEP_DATA_W-1:0]    pkt_fifo_tdata,
	input  logic [`DEP_KEEP_W-1:0]    pkt_fifo_tkeep,
	input  logic [`DEP_USER_W-1:0]    pkt_fifo_tuser,
	input  logic                      pkt_fifo_tlast,
	input  logic                      phv_fifo_empty,
	input  logic                      depar_out_tready,
	input  logic [`DEP_DATA_W-1:0]    beat_tdata,
	input  logic [`DEP_KEEP_W-1:0]    beat_tkeep,
	input  logic [`DEP_USER_W-1:0]    beat_tuser,
	input  logic                      beat_tlast,
	output logic                      pkt_fifo_rd_en,
	output logic                      phv_fifo_rd_en,
	output logic                      capture_lo,
	output logic                      capture_hi,
	output logic                      extract,
	output logic                      apply,
	output logic                      sel_hi,
	output logic [`DEP_DATA_W-1:0]    depar_out_tdata,
	output logic [`DEP_KEEP_W-1:0]    depar_out_tkeep,
	output logic [`DEP_USER_W-1:0]    depar_out_tuser,
	output logic                      depar_out_tvalid,
	output logic                      depar_out_tlast
);

	localparam logic [2:0] S_IDLE     = 3'd0;
	localparam logic [2:0] S_HDR_LO   = 3'd1;
	localparam logic [2:0] S_HDR_HI   = 3'd2;
	localparam logic [2:0] S_WAIT     = 3'd3;
	localparam logic [2:0] S_REWRITE  = 3'd4;
	localparam logic [2:0] S_FLUSH_LO = 3'd5;
	localparam logic [2:0] S_FLUSH_HI = 3'd6;
	localparam logic [2:0] S_BODY     = 3'd7;

	logic [2:0] state;
	logic [2:0] state_next;
	logic       wait_cnt;
	logic       out_free;
	logic       load_hdr;
	logic       pop_body;
	logic       load_out;

	// output register is empty or being taken this cycle
	assign out_free = !depar_out_tvalid || depar_out_tready;
	assign load_hdr = out_free && (state == S_FLUSH_LO || state == S_FLUSH_HI);
	assign pop_body = out_free && state == S_BODY && !pkt_fifo_empty;
	assign load_out = load_hdr || pop_body;

	// idle already saw both heads, so the first beat and the phv are there
	assign capture_lo     = state == S_HDR_LO;
	assign capture_hi     = state == S_HDR_HI && !pkt_fifo_empty;
	assign pkt_fifo_rd_en = capture_lo || capture_hi || pop_body;
	assign extract        = state == S_WAIT && wait_cnt;
	assign apply          = state == S_REWRITE;
	assign phv_fifo_rd_en = apply;
	assign sel_hi         = state == S_FLUSH_HI;

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE: if (!pkt_fifo_empty && !phv_fifo_empty && out_free)
				state_next = S_HDR_LO;
			S_HDR_LO: state_next = pkt_fifo_tlast ? S_WAIT : S_HDR_HI;
			S_HDR_HI: if (capture_hi)
				state_next = S_WAIT;
			// two cycles for table read and extraction
			S_WAIT: if (wait_cnt)
				state_next = S_REWRITE;
			S_REWRITE: state_next = S_FLUSH_LO;
			S_FLUSH_LO: if (load_hdr)
				state_next = beat_tlast ? S_IDLE : S_FLUSH_HI;
			S_FLUSH_HI: if (load_hdr)
				state_next = beat_tlast ? S_IDLE : S_BODY;
			S_BODY: if (pop_body && pkt_fifo_tlast)
				state_next = S_IDLE;
			default: state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state            <= S_IDLE;
			wait_cnt         <= 1'b0;
			depar_out_tvalid <= 1'b0;
			depar_out_tlast  <= 1'b0;
		end else begin
			state <= state_next;
			if (state == S_WAIT) begin
				wait_cnt <= !wait_cnt;
			end
			if (load_out) begin
				depar_out_tvalid <= 1'b1;
				depar_out_tlast  <= pop_body ? pkt_fifo_tlast : beat_tlast;
			end else if (depar_out_tready) begin
				depar_out_tvalid <= 1'b0;
				depar_out_tlast  <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_out) begin
			depar_out_tdata <= pop_body ? pkt_fifo_tdata : beat_tdata;
			depar_out_tkeep <= pop_body ? pkt_fifo_tkeep : beat_tkeep;
			depar_out_tuser <= pop_body ? pkt_fifo_tuser : beat_tuser;
		end
	end

	a_no_pop_when_empty: assert property (
		@(posedge clk) disable iff (!aresetn)
		!(pkt_fifo_rd_en && pkt_fifo_empty) && !(phv_fifo_rd_en && phv_fifo_empty)
	);

	a_out_stable: assert property (
		@(posedge clk) disable iff (!aresetn)
		depar_out_tvalid && !depar_out_tready |=> depar_out_tvalid &&
			$stable({depar_out_tdata, depar_out_tkeep, depar_out_tuser, depar_out_tlast})
	);

endmodule

`default_nettype wire

//--- rtl/header_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "deparser_params.svh"

module header_buffer (
	input  logic                      clk,
	input  logic                      aresetn,
	input  logic                      capture_lo,
	input  logic                      capture_hi,
	input  logic                      apply,
	input  logic [`DEP_DATA_W-1:0]    pkt_tdata,
	input  logic [`DEP_KEEP_W-1:0]    pkt_tkeep,
	input  logic [`DEP_USER_W-1:0]    pkt_tuser,
	input  logic                      pkt_tlast,
	input  logic [`DEP_OFS_W-1:0]     offsets [`DEP_NUM_ACT],
	input  logic [`DEP_VAL_W-1:0]     values [`DEP_NUM_ACT],
	input  logic [1:0]                sizes [`DEP_NUM_ACT],
	input  logic                      sel_hi,
	output logic [`DEP_DATA_W-1:0]    beat_tdata,
	output logic [`DEP_KEEP_W-1:0]    beat_tkeep,
	output logic [`DEP_USER_W-1:0]    beat_tuser,
	output logic                      beat_tlast
);

	localparam int HDR_BYTES = `DEP_HDR_W / 8;

	logic [`DEP_HDR_W-1:0]     hdr_data;
	logic [`DEP_HDR_W-1:0]     rewritten;
	logic [2*`DEP_KEEP_W-1:0]  hdr_keep;
	logic [2*`DEP_USER_W-1:0]  hdr_user;
	logic [1:0]                hdr_last;

	// actions in order, so the later one wins an overlap
	always_comb begin
		rewritten = hdr_data;
		for (int k = 0; k < `DEP_NUM_ACT; k++) begin
			case (sizes[k])
				2'd1: if (offsets[k] <= HDR_BYTES - 2)
					rewritten[offsets[k]*8 +: 16] = values[k][15:0];
				2'd2: if (offsets[k] <= HDR_BYTES - 4)
					rewritten[offsets[k]*8 +: 32] = values[k][31:0];
				2'd3: if (offsets[k] <= HDR_BYTES - 6)
					rewritten[offsets[k]*8 +: 48] = values[k][47:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (capture_lo) begin
			hdr_data[0 +: `DEP_DATA_W] <= pkt_tdata;
			hdr_keep[0 +: `DEP_KEEP_W] <= pkt_tkeep;
			hdr_user[0 +: `DEP_USER_W] <= pkt_tuser;
		end
		if (capture_hi) begin
			hdr_data[`DEP_DATA_W +: `DEP_DATA_W] <= pkt_tdata;
			hdr_keep[`DEP_KEEP_W +: `DEP_KEEP_W] <= pkt_tkeep;
			hdr_user[`DEP_USER_W +: `DEP_USER_W] <= pkt_tuser;
		end
		if (apply) begin
			hdr_data <= rewritten;
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			hdr_last <= 2'b00;
		end else begin
			if (capture_lo) begin
				hdr_last[0] <= pkt_tlast;
			end
			if (capture_hi) begin
				hdr_last[1] <= pkt_tlast;
			end
		end
	end

	assign beat_tdata = sel_hi ? hdr_data[`DEP_DATA_W +: `DEP_DATA_W] : hdr_data[0 +: `DEP_DATA_W];
	assign beat_tkeep = sel_hi ? hdr_keep[`DEP_KEEP_W +: `DEP_KEEP_W] : hdr_keep[0 +: `DEP_KEEP_W];
	assign beat_tuser = sel_hi ? hdr_user[`DEP_USER_W +: `DEP_USER_W] : hdr_user[0 +: `DEP_USER_W];
	assign beat_tlast = sel_hi ? hdr_last[1] : hdr_last[0];

	a_no_capture_on_apply: assert property (
		@(posedge clk) disable iff (!aresetn)
		apply |-> !(capture_lo || capture_hi)
	);

endmodule

`default_nettype wire

//--- rtl/container_extract.sv
`timescale 1ns/10ps
`default_nettype none

`include "deparser_params.svh"

module container_extract (
	input  logic                         clk,
	input  logic                         aresetn,
	input  logic                         extract,
	input  logic [`DEP_CONT_W-1:0]       containers,
	input  deparser_pkg::parse_action_u  action,
	output logic [`DEP_VAL_W-1:0]        value,
	output logic [1:0]                   size
);

	logic [`DEP_VAL_W-1:0] sel_value;
	logic [2:0]            idx;

	assign idx = action.fields.cont_index;

	// pick the container out of its size class
	always_comb begin
		sel_value = '0;
		case (action.fields.cont_type)
			2'd1: sel_value = {32'd0, containers[`DEP_CONT2_OFS + idx*16 +: 16]};
			2'd2: sel_value = {16'd0, containers[`DEP_CONT4_OFS + idx*32 +: 32]};
			2'd3: sel_value = containers[`DEP_CONT6_OFS + idx*48 +: 48];
			default: sel_value = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (extract) begin
			value <= sel_value;
		end
	end

	// size 0 tells the buffer to skip this action
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			size <= 2'd0;
		end else if (extract) begin
			if (action.fields.valid) begin
				size <= action.fields.cont_type;
			end else begin
				size <= 2'd0;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/parse_action_table.sv
`timescale 1ns/10ps
`default_nettype none

`include "deparser_params.svh"

module parse_action_table (
	input  logic                          clk,
	input  logic                          aresetn,
	input  logic                          tbl_wr_en,
	input  logic [`DEP_TBL_ADDR_W-1:0]    tbl_wr_addr,
	input  logic [`DEP_ENTRY_W-1:0]       tbl_wr_data,
	input  logic [`DEP_VLAN_W-1:0]        vlan_id,
	output deparser_pkg::parse_action_u   actions [`DEP_NUM_ACT]
);

	logic [`DEP_ENTRY_W-1:0]     mem [`DEP_TBL_DEPTH];
	logic [`DEP_ENTRY_W-1:0]     rd_entry;
	logic [`DEP_TBL_ADDR_W-1:0]  rd_addr;

	// entry chosen by the middle nibble of the vlan id
	assign rd_addr = vlan_id[7:4];

	always_ff @(posedge clk) begin
		if (tbl_wr_en) begin
			mem[tbl_wr_addr] <= tbl_wr_data;
		end
		rd_entry <= mem[rd_addr];
	end

	// second stage splits the entry into action words
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			for (int k = 0; k < `DEP_NUM_ACT; k++) begin
				actions[k] <= '0;
			end
		end else begin
			for (int k = 0; k < `DEP_NUM_ACT; k++) begin
				actions[k].raw <= rd_entry[k*`DEP_ACT_W +: `DEP_ACT_W];
			end
		end
	end

	a_wr_known: assert property (
		@(posedge clk) disable iff (!aresetn)
		tbl_wr_en |-> !$isunknown({tbl_wr_addr, tbl_wr_data})
	);

endmodule

`default_nettype wire

//--- rtl/deparser_pkg.sv
`default_nettype none

`include "deparser_params.svh"

package deparser_pkg;

	// one action word with the valid flag in bit 0
	typedef struct packed {
		logic [2:0]             reserved;
		logic [`DEP_OFS_W-1:0]  byte_offset;
		logic [1:0]             cont_type;
		logic [2:0]             cont_index;
		logic                   valid;
	} parse_action_t;

	typedef union packed {
		logic [`DEP_ACT_W-1:0]  raw;
		parse_action_t          fields;
	} parse_action_u;

endpackage

`default_nettype wire

//--- include/deparser_params.svh
`ifndef DEPARSER_PARAMS_SVH
`define DEPARSER_PARAMS_SVH

// packet beats
`define DEP_DATA_W      256
`define DEP_KEEP_W      32
`define DEP_USER_W      128
`define DEP_HDR_W       512

// packet header vector
`define DEP_PHV_W       1124
`define DEP_VLAN_LSB    129
`define DEP_VLAN_W      12
`define DEP_CONT_LSB    356
`define DEP_CONT_W      768
`define DEP_CONT_NUM    8
`define DEP_CONT2_OFS   0
`define DEP_CONT4_OFS   128
`define DEP_CONT6_OFS   384
`define DEP_VAL_W       48

// parse action table
`define DEP_NUM_ACT     10
`define DEP_ACT_W       16
`define DEP_OFS_W       7
`define DEP_TBL_DEPTH   16
`define DEP_TBL_ADDR_W  4
`define DEP_ENTRY_W     160

`endif
